/* hw/mips_ex_pkg.sv */
`default_nettype none

package mips_ex_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT_W    = 6;
    localparam int ALU_OP_W   = 3;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    // R-type funct field codes
    localparam logic [FUNCT_W-1:0] FN_SLL  = 6'h00;
    localparam logic [FUNCT_W-1:0] FN_SRL  = 6'h02;
    localparam logic [FUNCT_W-1:0] FN_SRA  = 6'h03;
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'h04;
    localparam logic [FUNCT_W-1:0] FN_SRLV = 6'h06;
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'h07;
    localparam logic [FUNCT_W-1:0] FN_ADD  = 6'h20;
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNCT_W-1:0] FN_SUB  = 6'h22;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
    localparam logic [FUNCT_W-1:0] FN_NOR  = 6'h27;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;
    localparam logic [FUNCT_W-1:0] FN_SLTU = 6'h2b;

    // Op class from the main decoder
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_OP_ADD   = 3'd0,  // loads and stores
        ALU_OP_SUB   = 3'd1,  // branch compare
        ALU_OP_RTYPE = 3'd2,
        ALU_OP_AND   = 3'd3,
        ALU_OP_OR    = 3'd4,
        ALU_OP_XOR   = 3'd5,
        ALU_OP_SLT   = 3'd6,
        ALU_OP_LUI   = 3'd7
    } alu_op_e;

    // Function actually run by the ALU
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_func_e;

    ////////////////////////////////////////////////////////////
    // Low half-word of the instruction
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [SHAMT_W-1:0]    shamt;
        logic [FUNCT_W-1:0]    funct;
    } r_fmt_t;

    // Same bits seen as R-format fields or as the raw immediate
    typedef union packed {
        r_fmt_t           r_fmt;
        logic [IMM_W-1:0] i_fmt;
    } imm_field_u;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic    reg_dst;
        logic    alu_src;
        logic    shift_src;
        alu_op_e alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
    } ex_ctrl_t;

    typedef struct packed {
        ex_ctrl_t              ctrl;
        logic [DATA_W-1:0]     ra_data;
        logic [DATA_W-1:0]     rb_data;
        imm_field_u            imm;
        logic [REG_ADDR_W-1:0] rt;
    } id_ex_t;

    typedef struct packed {
        logic [DATA_W-1:0]     alu_data;
        logic [DATA_W-1:0]     mem_data;
        logic [REG_ADDR_W-1:0] reg_address;
        logic                  zero;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } ex_mem_t;

endpackage

`default_nettype wire

/* hw/alu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_control
    import mips_ex_pkg::*;
(
    input  wire alu_op_e              i_alu_op,
    input  wire logic [FUNCT_W-1:0]   i_funct,
    output alu_func_e                 o_alu_func
);

    always_comb begin
        // Safe fallback for anything undecoded
        o_alu_func = ALU_ADD;
        case (i_alu_op)
            // Immediate and memory classes map one to one
            ALU_OP_ADD: o_alu_func = ALU_ADD;
            ALU_OP_SUB: o_alu_func = ALU_SUB;
            ALU_OP_AND: o_alu_func = ALU_AND;
            ALU_OP_OR:  o_alu_func = ALU_OR;
            ALU_OP_XOR: o_alu_func = ALU_XOR;
            ALU_OP_SLT: o_alu_func = ALU_SLT;
            ALU_OP_LUI: o_alu_func = ALU_LUI;
            // R-type looks at funct
            ALU_OP_RTYPE: begin
                case (i_funct)
                    // Overflow traps not modelled, signed and unsigned alike
                    FN_ADD, FN_ADDU: o_alu_func = ALU_ADD;
                    FN_SUB, FN_SUBU: o_alu_func = ALU_SUB;
                    FN_AND:          o_alu_func = ALU_AND;
                    FN_OR:           o_alu_func = ALU_OR;
                    FN_XOR:          o_alu_func = ALU_XOR;
                    FN_NOR:          o_alu_func = ALU_NOR;
                    FN_SLT:          o_alu_func = ALU_SLT;
                    FN_SLTU:         o_alu_func = ALU_SLTU;
                    // Fixed and variable shifts share a code
                    FN_SLL, FN_SLLV: o_alu_func = ALU_SLL;
                    FN_SRL, FN_SRLV: o_alu_func = ALU_SRL;
                    FN_SRA, FN_SRAV: o_alu_func = ALU_SRA;
                    default:         o_alu_func = ALU_ADD;
                endcase
            end
            default: o_alu_func = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu
    import mips_ex_pkg::*;
(
    input  wire logic [DATA_W-1:0] i_data_a,
    input  wire logic [DATA_W-1:0] i_data_b,
    input  wire alu_func_e         i_alu_func,
    output logic [DATA_W-1:0]      o_result,
    output logic                   o_zero
);

    // Shift amount from operand A, shamt or rs
    logic [SHAMT_W-1:0] shift_amt;
    // Compare outcomes
    logic               lt_signed;
    logic               lt_unsigned;

    assign shift_amt   = i_data_a[SHAMT_W-1:0];
    assign lt_signed   = $signed(i_data_a) < $signed(i_data_b);
    assign lt_unsigned = i_data_a < i_data_b;

    ////////////////////////////////////////////////////////////
    // Function select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (i_alu_func)
            ALU_ADD:  o_result = i_data_a + i_data_b;
            ALU_SUB:  o_result = i_data_a - i_data_b;
            ALU_AND:  o_result = i_data_a & i_data_b;
            ALU_OR:   o_result = i_data_a | i_data_b;
            ALU_XOR:  o_result = i_data_a ^ i_data_b;
            ALU_NOR:  o_result = ~(i_data_a | i_data_b);
            // Compares give 0 or 1
            ALU_SLT:  o_result = {{(DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: o_result = {{(DATA_W-1){1'b0}}, lt_unsigned};
            // Shifts move B, never A
            ALU_SLL:  o_result = i_data_b << shift_amt;
            ALU_SRL:  o_result = i_data_b >> shift_amt;
            ALU_SRA:  o_result = $unsigned($signed(i_data_b) >>> shift_amt);
            // Upper half from the immediate, lower half cleared
            ALU_LUI:  o_result = {i_data_b[IMM_W-1:0], {(DATA_W-IMM_W){1'b0}}};
            default:  o_result = '0;
        endcase
    end

    // Branch compare flag
    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* hw/execution.sv */
`timescale 1ns/1ns
`default_nettype none

module execution
    import mips_ex_pkg::*;
(
    input  wire logic   i_valid,
    input  wire id_ex_t i_id_ex,
    output ex_mem_t     o_ex_mem
);

    ex_ctrl_t          ctrl;
    logic [DATA_W-1:0] sign_ext_data;
    logic [DATA_W-1:0] alu_data_a;
    logic [DATA_W-1:0] alu_data_b;
    logic [DATA_W-1:0] alu_result;
    alu_func_e         alu_func;
    logic              alu_zero;

    assign ctrl = i_id_ex.ctrl;

    ////////////////////////////////////////////////////////////
    // Operand and destination selection
    ////////////////////////////////////////////////////////////
    // Replicate bit 15 of the I-format view
    assign sign_ext_data = {{(DATA_W-IMM_W){i_id_ex.imm.i_fmt[IMM_W-1]}}, i_id_ex.imm.i_fmt};

    // Fixed shifts take shamt, everything else rs
    assign alu_data_a = ctrl.shift_src
                      ? {{(DATA_W-SHAMT_W){1'b0}}, i_id_ex.imm.r_fmt.shamt}
                      : i_id_ex.ra_data;
    // Immediate classes and memory ops take the offset
    assign alu_data_b = ctrl.alu_src ? sign_ext_data : i_id_ex.rb_data;

    alu_control u_alu_control (
        .i_alu_op   (ctrl.alu_op),
        .i_funct    (i_id_ex.imm.r_fmt.funct),
        .o_alu_func (alu_func)
    );

    alu u_alu (
        .i_data_a   (alu_data_a),
        .i_data_b   (alu_data_b),
        .i_alu_func (alu_func),
        .o_result   (alu_result),
        .o_zero     (alu_zero)
    );

    always_comb begin
        o_ex_mem.alu_data    = alu_result;
        // Store data is rt straight through
        o_ex_mem.mem_data    = i_id_ex.rb_data;
        // rd for R-type, rt for immediates and loads
        o_ex_mem.reg_address = ctrl.reg_dst ? i_id_ex.imm.r_fmt.rd : i_id_ex.rt;
        o_ex_mem.zero        = alu_zero;
        o_ex_mem.mem_read    = ctrl.mem_read;
        o_ex_mem.mem_write   = ctrl.mem_write;
        o_ex_mem.reg_write   = ctrl.reg_write;
    end

    // Decoder must never ask for a load and store together
    a_no_rd_wr: assert final (!(i_valid && ctrl.mem_read && ctrl.mem_write))
        else $error("valid item with both mem_read and mem_write");

endmodule

`default_nettype wire

/* hw/id_ex_register.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_register
    import mips_ex_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_arst_n,
    input  wire logic   i_valid,
    input  wire id_ex_t i_id_ex,
    output logic        o_valid,
    output id_ex_t      o_id_ex
);

    ex_ctrl_t ctrl_q;
    id_ex_t   data_q;

    // Control flops, cleared on reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            ctrl_q  <= '0;
        end else begin
            o_valid <= i_valid;
            ctrl_q  <= i_id_ex.ctrl;
            // Bubble never writes memory or registers
            if (!i_valid) begin
                ctrl_q.mem_read  <= 1'b0;
                ctrl_q.mem_write <= 1'b0;
                ctrl_q.reg_write <= 1'b0;
            end
        end
    end

    // Operands and immediate
    always_ff @(posedge i_clk) begin
        data_q <= i_id_ex;
    end

    always_comb begin
        o_id_ex      = data_q;
        o_id_ex.ctrl = ctrl_q;
    end

endmodule

`default_nettype wire

/* hw/ex_mem_register.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_mem_register
    import mips_ex_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_arst_n,
    input  wire logic    i_valid,
    input  wire ex_mem_t i_ex_mem,
    output logic         o_valid,
    output ex_mem_t      o_ex_mem
);

    ex_mem_t data_q;
    logic    mem_read_q;
    logic    mem_write_q;
    logic    reg_write_q;

    // Valid and write enables
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid     <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            reg_write_q <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            mem_read_q  <= i_valid & i_ex_mem.mem_read;
            mem_write_q <= i_valid & i_ex_mem.mem_write;
            reg_write_q <= i_valid & i_ex_mem.reg_write;
        end
    end

    // Result, store data, destination, flag
    always_ff @(posedge i_clk) begin
        data_q <= i_ex_mem;
    end

    always_comb begin
        o_ex_mem           = data_q;
        o_ex_mem.mem_read  = mem_read_q;
        o_ex_mem.mem_write = mem_write_q;
        o_ex_mem.reg_write = reg_write_q;
    end

    // ID/EX hands over bubbles with writes already cleared
    a_bubble_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !i_valid |-> !(i_ex_mem.mem_read || i_ex_mem.mem_write || i_ex_mem.reg_write))
        else $error("write control set on a bubble entering EX/MEM");

endmodule

`default_nettype wire

/* hw/ex_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_pipeline
    import mips_ex_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_arst_n,
    input  wire logic   i_valid,
    input  wire id_ex_t i_id_ex,
    output logic        o_valid,
    output ex_mem_t     o_ex_mem
);

    ////////////////////////////////////////////////////////////
    // ID/EX -> execute -> EX/MEM, two cycles end to end
    ////////////////////////////////////////////////////////////
    logic    ex_valid;
    id_ex_t  ex_id_ex;
    ex_mem_t ex_result;

    id_ex_register u_id_ex_register (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_id_ex  (i_id_ex),
        .o_valid  (ex_valid),
        .o_id_ex  (ex_id_ex)
    );

    // Purely combinational between the two registers
    execution u_execution (
        .i_valid  (ex_valid),
        .i_id_ex  (ex_id_ex),
        .o_ex_mem (ex_result)
    );

    ex_mem_register u_ex_mem_register (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (ex_valid),
        .i_ex_mem (ex_result),
        .o_valid  (o_valid),
        .o_ex_mem (o_ex_mem)
    );

endmodule

`default_nettype wire

/* testbench/ex_pipeline_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_pipeline_tb
    import mips_ex_pkg::*;
();

    ////////////////////////////////////////////////////////////
    // Run length and vector layout
    ////////////////////////////////////////////////////////////
    localparam int NUM_VEC      = 31;
    // Ten hex words per line of the input file
    localparam int WORDS        = 10;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 10;
    // Reset, vectors and drain all fit well inside this
    localparam int CYCLE_LIMIT  = NUM_VEC + 20;

    logic        i_clk;
    logic        i_arst_n;
    logic        i_valid;
    id_ex_t      i_id_ex;
    logic        o_valid;
    ex_mem_t     o_ex_mem;
    logic [31:0] vectors [0:NUM_VEC*WORDS-1];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    ex_pipeline i_ex_pipeline (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_id_ex  (i_id_ex),
        .o_valid  (o_valid),
        .o_ex_mem (o_ex_mem)
    );

    // 100 ns period
    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // Hard stop if the main sequence stalls
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Drive and compare one vector
    ////////////////////////////////////////////////////////////
    // Word 1 is {valid, reg_dst, alu_src, shift_src, alu_op, mem_read, mem_write, reg_write}
    task automatic drive_vector(input int vec_idx);
        int base;
        base = vec_idx * WORDS;
        if (vec_idx < NUM_VEC) begin
            i_valid         = vectors[base+1][9];
            i_id_ex.ctrl    = ex_ctrl_t'(vectors[base+1][8:0]);
            i_id_ex.ra_data = vectors[base+2];
            i_id_ex.rb_data = vectors[base+3];
            i_id_ex.imm     = imm_field_u'(vectors[base+4][15:0]);
            i_id_ex.rt      = vectors[base+5][4:0];
        end else begin
            // Drain with idle cycles
            i_valid = 1'b0;
            i_id_ex = '0;
        end
    endtask

    task automatic check_output(input int vec_idx);
        int          base;
        string       tag;
        logic [31:0] flag_mask;
        logic [31:0] got_flags;
        base = vec_idx * WORDS;
        tag  = $sformatf("test %0h", vectors[base]);
        // Zero flag of a bubble is meaningless
        flag_mask = vectors[base+9][4] ? 32'h1f : 32'h17;
        got_flags = 32'({o_valid, o_ex_mem.zero, o_ex_mem.mem_read,
                         o_ex_mem.mem_write, o_ex_mem.reg_write});
        check_value({tag, " flags"}, vectors[base+9] & flag_mask, got_flags & flag_mask);
        // Payload only matters for a live item
        if (vectors[base+9][4]) begin
            check_value({tag, " alu_data"}, vectors[base+6], o_ex_mem.alu_data);
            check_value({tag, " mem_data"}, vectors[base+7], o_ex_mem.mem_data);
            check_value({tag, " reg_address"}, vectors[base+8], 32'(o_ex_mem.reg_address));
        end
    endtask

    task automatic check_idle(input string name);
        check_value({name, " o_valid"}, 32'h0, 32'(o_valid));
        check_value({name, " write controls"}, 32'h0,
                    32'({o_ex_mem.mem_read, o_ex_mem.mem_write, o_ex_mem.reg_write}));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_id_ex  = '0;
        $readmemh("testbench/ex_pipeline_input.txt", vectors);
        repeat (RESET_CYCLES) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            check_idle("reset");
        end
        i_arst_n = 1'b1;
        // Output after edge N+2 belongs to the vector driven after edge N
        for (int idx = 0; idx < NUM_VEC + 2; idx++) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            if (idx >= 2) begin
                check_output(idx - 2);
            end else begin
                check_idle("after reset");
            end
            drive_vector(idx);
        end
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/ex_pipeline_input.txt */
// test {valid,ctrl} ra_data rb_data imm rt | alu_data mem_data reg_address
// {valid,zero,mem_read,mem_write,reg_write}
01 311 00000005 00000007 1820 02 0000000C 00000007 03 11
02 311 FFFFFFFF 00000001 1821 02 00000000 00000001 03 19
03 311 00000010 00000003 1822 02 0000000D 00000003 03 11
04 311 00000003 00000005 1823 02 FFFFFFFE 00000005 03 11
05 311 F0F0F0F0 FF00FF00 1824 02 F000F000 FF00FF00 03 11
06 311 F0F0F0F0 0F0F0000 1825 02 FFFFF0F0 0F0F0000 03 11
07 311 FFFF0000 FF00FF00 1826 02 00FFFF00 FF00FF00 03 11
08 311 F0F0F0F0 0F0F0000 1827 02 00000F0F 0F0F0000 03 11
09 311 FFFFFFFE 00000001 182A 02 00000001 00000001 03 11
0A 311 FFFFFFFE 00000001 182B 02 00000000 00000001 03 19
0B 311 00000100 00000023 183F 02 00000123 00000023 03 11
0C 111 00000001 00000002 1820 02 00000000 00000000 00 00
0D 351 DEADBEEF 0000000F 1900 02 000000F0 0000000F 03 11
0E 351 12345678 80000000 1A02 02 00800000 80000000 03 11
0F 351 12345678 80000000 1903 02 F8000000 80000000 03 11
10 311 00000003 00000011 1804 02 00000088 00000011 03 11
11 311 00000024 F0000000 1806 02 0F000000 F0000000 03 11
12 311 0000001F 80000000 1807 02 FFFFFFFF 80000000 03 11
13 082 10000000 CAFEF00D 0004 07 00000000 00000000 00 00
14 085 10000000 00000000 0004 06 00000000 00000000 00 00
15 281 00000010 AAAAAAAA FFFC 05 0000000C AAAAAAAA 05 11
16 299 1234F0F0 AAAAAAAA 8F0F 05 12348000 AAAAAAAA 05 11
17 2A1 12340000 AAAAAAAA 00FF 05 123400FF AAAAAAAA 05 11
18 2A9 0000FFFF AAAAAAAA FFFF 05 FFFF0000 AAAAAAAA 05 11
19 2B1 FFFFFFE0 AAAAAAAA FFF0 05 00000001 AAAAAAAA 05 11
1A 2B9 00000000 AAAAAAAA ABCD 05 ABCD0000 AAAAAAAA 05 11
1B 285 10000000 55555555 0008 06 10000008 55555555 06 15
1C 282 10000100 CAFEF00D FFFC 07 100000FC CAFEF00D 07 12
1D 111 00000005 00000005 1822 02 00000000 00000000 00 00
1E 208 00001234 00001234 0010 08 00000000 00001234 08 18
1F 208 00001234 00001233 0010 08 00000001 00001233 08 10

/* flist.f */
hw/mips_ex_pkg.sv
hw/alu_control.sv
hw/alu.sv
hw/execution.sv
hw/id_ex_register.sv
hw/ex_mem_register.sv
hw/ex_pipeline.sv
testbench/ex_pipeline_tb.sv

/* Makefile */
TOP := ex_pipeline_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
